//--- decoder_ctrl_pkg.sv
package decoder_ctrl_pkg;

    // iteration count width, up to 255 iterations
    localparam int iteration_width = 8;

    // decoder stages
    typedef enum logic [2:0] {
        stage_idle    = 3'd0,
        stage_loading = 3'd1,
        stage_spread  = 3'd2,
        stage_sync    = 3'd3,
        stage_grow    = 3'd4,
        stage_result  = 3'd5
    } stage_t;

    // command kinds sent to the processing array
    typedef enum logic [2:0] {
        op_start   = 3'd1,
        op_advance = 3'd2,
        op_finish  = 3'd3,
        op_abort   = 3'd4
    } opcode_t;

    // command message, 11 bits
    typedef struct packed {
        opcode_t                    opcode;
        logic [iteration_width-1:0] iteration;
    } ctrl_msg_t;

    // per-cycle sequencer status, 6 bits
    typedef struct packed {
        stage_t stage;
        logic   iteration_done;
        logic   round_done;
        logic   round_aborted;
    } seq_status_t;

endpackage

//--- command_fifo.sv
`timescale 1ns/10ps

module command_fifo import decoder_ctrl_pkg::*; #(
    parameter int depth = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  ctrl_msg_t push_msg,
    input  logic      pop,
    output logic      full,
    output ctrl_msg_t msg_out,
    output logic      msg_valid
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    ctrl_msg_t              mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   empty;
    logic                   do_push;
    logic                   do_pop;

    assign empty   = (count == '0);
    assign full    = (count == count_width'(depth));
    assign do_push = push && !full;
    // ready on an empty fifo is ignored
    assign do_pop  = pop && !empty;

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_msg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head word falls through, held until popped
    assign msg_out   = mem[rd_ptr];
    assign msg_valid = !empty;

    pop_empty_noop: assert property (@(posedge clk) disable iff (reset)
        (pop && empty && !push) |=> ($stable(rd_ptr) && $stable(count)));

endmodule

//--- stage_sequencer.sv
`timescale 1ns/10ps

module stage_sequencer import decoder_ctrl_pkg::*; #(
    parameter int spread_delay = 2,
    parameter int sync_delay   = 2,
    parameter int grow_delay   = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       new_round_start,
    input  logic                       messages_flying,
    input  logic                       odd_clusters,
    input  logic                       stall_expired,
    input  logic                       fifo_full,
    input  logic [iteration_width-1:0] iteration,
    output seq_status_t                status,
    output logic                       push,
    output ctrl_msg_t                  push_msg
);

    // delay counter sized from the longest settling delay
    localparam int max_delay = (spread_delay > sync_delay) ?
        ((spread_delay > grow_delay) ? spread_delay : grow_delay) :
        ((sync_delay > grow_delay) ? sync_delay : grow_delay);
    localparam int delay_width = $clog2(max_delay + 2);

    stage_t                 stage;
    stage_t                 next_stage;
    logic [delay_width-1:0] delay_cnt;
    logic [delay_width-1:0] stage_delay;
    logic                   delay_done;
    logic                   start_pending;
    logic                   iteration_done;
    logic                   round_aborted;

    // settling delay of the current stage
    always_comb begin
        case (stage)
            stage_spread: stage_delay = delay_width'(spread_delay);
            stage_sync:   stage_delay = delay_width'(sync_delay);
            stage_grow:   stage_delay = delay_width'(grow_delay);
            default:      stage_delay = '0;
        endcase
    end

    assign delay_done = (delay_cnt >= stage_delay);

    // transition decision and the command that announces it
    always_comb begin
        next_stage         = stage;
        push               = 1'b0;
        push_msg.opcode    = op_advance;
        push_msg.iteration = iteration;
        iteration_done     = 1'b0;
        round_aborted      = 1'b0;
        case (stage)
            stage_idle: begin
                // a fresh round always starts at iteration zero
                if ((new_round_start || start_pending) && !fifo_full) begin
                    push               = 1'b1;
                    push_msg.opcode    = op_start;
                    push_msg.iteration = '0;
                    next_stage         = stage_loading;
                end
            end
            stage_loading: begin
                // single cycle, nothing announced
                next_stage = stage_spread;
            end
            stage_spread: begin
                if (delay_done && !fifo_full) begin
                    if (!messages_flying) begin
                        push       = 1'b1;
                        next_stage = stage_sync;
                    end else if (stall_expired) begin
                        push            = 1'b1;
                        push_msg.opcode = op_abort;
                        round_aborted   = 1'b1;
                        next_stage      = stage_idle;
                    end
                end
            end
            stage_sync: begin
                if (delay_done && !fifo_full) begin
                    if (!messages_flying) begin
                        push           = 1'b1;
                        iteration_done = 1'b1;
                        if (odd_clusters) begin
                            next_stage = stage_grow;
                        end else begin
                            push_msg.opcode = op_finish;
                            next_stage      = stage_result;
                        end
                    end else if (stall_expired) begin
                        push            = 1'b1;
                        push_msg.opcode = op_abort;
                        round_aborted   = 1'b1;
                        next_stage      = stage_idle;
                    end
                end
            end
            stage_grow: begin
                if (delay_done && !messages_flying && !fifo_full) begin
                    push       = 1'b1;
                    next_stage = stage_spread;
                end
            end
            stage_result: begin
                next_stage = stage_idle;
            end
            default: begin
                next_stage = stage_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage         <= stage_idle;
            delay_cnt     <= '0;
            start_pending <= 1'b0;
        end else begin
            stage <= next_stage;
            // count restarts on entry, saturates at the stage delay
            if (next_stage != stage) begin
                delay_cnt <= '0;
            end else if (!delay_done) begin
                delay_cnt <= delay_cnt + 1'b1;
            end
            // start seen while the fifo is full is kept until it can be sent
            if (stage == stage_idle) begin
                start_pending <= (new_round_start || start_pending) && fifo_full;
            end else begin
                start_pending <= 1'b0;
            end
        end
    end

    assign status.stage          = stage;
    assign status.iteration_done = iteration_done;
    assign status.round_done     = (stage == stage_result);
    assign status.round_aborted  = round_aborted;

    // fifo full must hold every announcing transition
    push_not_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !fifo_full);

    stage_defined: assert property (@(posedge clk) disable iff (reset)
        stage inside {stage_idle, stage_loading, stage_spread,
                      stage_sync, stage_grow, stage_result});

endmodule

//--- stall_watchdog.sv
`timescale 1ns/10ps

module stall_watchdog import decoder_ctrl_pkg::*; #(
    parameter int deadlock_threshold = 40
) (
    input  logic        clk,
    input  logic        reset,
    input  seq_status_t status,
    input  logic        new_round_start,
    output logic        stall_expired,
    output logic        deadlock
);

    // holds up to threshold+1, then saturates
    localparam int count_width = $clog2(deadlock_threshold + 2);

    logic [count_width-1:0] stall_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cnt <= '0;
        end else if (status.stage == stage_spread || status.stage == stage_sync) begin
            // runs on across spread and sync until it saturates
            if (!stall_expired) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
        end else if (status.stage != stage_result) begin
            // loading, grow and idle restart the count
            stall_cnt <= '0;
        end
    end

    assign stall_expired = (stall_cnt > count_width'(deadlock_threshold));

    // latched until the next round starts
    always_ff @(posedge clk) begin
        if (reset) begin
            deadlock <= 1'b0;
        end else if (new_round_start) begin
            deadlock <= 1'b0;
        end else if (status.round_aborted) begin
            deadlock <= 1'b1;
        end
    end

endmodule

//--- round_statistics.sv
`timescale 1ns/10ps

module round_statistics import decoder_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  seq_status_t                status,
    input  logic                       new_round_start,
    output logic [iteration_width-1:0] iteration_counter,
    output logic [31:0]                cycle_counter,
    output logic                       result_valid
);

    // one count per sync exit, cleared in loading
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
        end else if (status.stage == stage_loading) begin
            iteration_counter <= '0;
        end else if (status.iteration_done) begin
            iteration_counter <= iteration_counter + 1'b1;
        end
    end

    // loading counts as cycle one
    // frozen once the sequencer is back in idle
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_counter <= '0;
        end else if (status.stage == stage_loading) begin
            cycle_counter <= 32'd1;
        end else if (status.stage != stage_idle) begin
            cycle_counter <= cycle_counter + 32'd1;
        end
    end

    // marks a completed round, never an aborted one
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (new_round_start) begin
            result_valid <= 1'b0;
        end else if (status.round_done) begin
            result_valid <= 1'b1;
        end
    end

    done_xor_abort: assert property (@(posedge clk) disable iff (reset)
        !(status.round_done && status.round_aborted));

endmodule

//--- decoder_controller.sv
`timescale 1ns/10ps

module decoder_controller import decoder_ctrl_pkg::*; #(
    parameter int spread_delay       = 2,
    parameter int sync_delay         = 2,
    parameter int grow_delay         = 3,
    parameter int deadlock_threshold = 40,
    parameter int fifo_depth         = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       new_round_start,
    input  logic                       messages_flying,
    input  logic                       odd_clusters,
    input  logic                       msg_ready,
    output ctrl_msg_t                  msg_out,
    output logic                       msg_valid,
    output logic                       result_valid,
    output logic [iteration_width-1:0] iteration_counter,
    output logic [31:0]                cycle_counter,
    output logic                       deadlock
);

    seq_status_t seq_status;
    ctrl_msg_t   push_msg;
    logic        push;
    logic        fifo_full;
    logic        stall_expired;

    // stage fsm, announces each transition
    stage_sequencer #(
        .spread_delay (spread_delay),
        .sync_delay   (sync_delay),
        .grow_delay   (grow_delay)
    ) u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .new_round_start (new_round_start),
        .messages_flying (messages_flying),
        .odd_clusters    (odd_clusters),
        .stall_expired   (stall_expired),
        .fifo_full       (fifo_full),
        .iteration       (iteration_counter),
        .status          (seq_status),
        .push            (push),
        .push_msg        (push_msg)
    );

    stall_watchdog #(
        .deadlock_threshold (deadlock_threshold)
    ) u_watchdog (
        .clk             (clk),
        .reset           (reset),
        .status          (seq_status),
        .new_round_start (new_round_start),
        .stall_expired   (stall_expired),
        .deadlock        (deadlock)
    );

    round_statistics u_statistics (
        .clk               (clk),
        .reset             (reset),
        .status            (seq_status),
        .new_round_start   (new_round_start),
        .iteration_counter (iteration_counter),
        .cycle_counter     (cycle_counter),
        .result_valid      (result_valid)
    );

    // outgoing commands, msg_ready pops
    command_fifo #(
        .depth (fifo_depth)
    ) u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_msg  (push_msg),
        .pop       (msg_ready),
        .full      (fifo_full),
        .msg_out   (msg_out),
        .msg_valid (msg_valid)
    );

endmodule

//--- ctrl_checker.sv
`timescale 1ns/10ps

module ctrl_checker import decoder_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  ctrl_msg_t                  msg_out,
    input  logic                       msg_valid,
    input  logic                       msg_ready,
    input  logic                       result_valid,
    input  logic [iteration_width-1:0] iteration_counter,
    input  logic [31:0]                cycle_counter,
    input  logic                       deadlock,
    input  logic                       row_start,
    input  logic                       row_end,
    input  logic [7:0]                 row_k,
    input  logic                       row_abort,
    input  logic [iteration_width-1:0] exp_iter,
    input  logic [31:0]                exp_cycles,
    output int                         pending,
    output int                         error_count,
    output int                         rows_checked
);

    ctrl_msg_t exp_q [$];
    ctrl_msg_t exp_msg;
    ctrl_msg_t held_msg;
    logic      held;
    logic      abort_q;
    logic      in_row;
    logic      level_err;
    int        errors_at_start;

    function automatic ctrl_msg_t make_msg(opcode_t op, int iter);
        ctrl_msg_t m;
        m.opcode    = op;
        m.iteration = iteration_width'(iter);
        return m;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            held            = 1'b0;
            abort_q         = 1'b0;
            in_row          = 1'b0;
            level_err       = 1'b0;
            errors_at_start = 0;
            pending         = 0;
            error_count     = 0;
            rows_checked    = 0;
        end else begin
            if (row_start) begin
                // build the expected command stream of this round
                exp_q.delete();
                exp_q.push_back(make_msg(op_start, 0));
                if (row_abort) begin
                    exp_q.push_back(make_msg(op_abort, 0));
                end else begin
                    for (int i = 0; i < int'(row_k); i++) begin
                        // spread exit, then sync exit before its count bump
                        exp_q.push_back(make_msg(op_advance, i));
                        exp_q.push_back(make_msg(op_advance, i));
                        // grow exit already sees the new count
                        exp_q.push_back(make_msg(op_advance, i + 1));
                    end
                    exp_q.push_back(make_msg(op_advance, int'(row_k)));
                    exp_q.push_back(make_msg(op_finish, int'(row_k)));
                end
                abort_q         = row_abort;
                in_row          = 1'b1;
                level_err       = 1'b0;
                errors_at_start = error_count;
            end else if (in_row && !level_err) begin
                // flags cleared by the start pulse must stay as the round demands
                if (abort_q && result_valid) begin
                    $display("%0t: result_valid raised during an aborted round", $time);
                    error_count++;
                    level_err = 1'b1;
                end else if (!abort_q && deadlock) begin
                    $display("%0t: deadlock raised during a normal round", $time);
                    error_count++;
                    level_err = 1'b1;
                end
            end
            // a stalled head word must not move or vanish
            if (held && (!msg_valid || msg_out != held_msg)) begin
                $display("MISMATCH %0t msg_out expected 0x%03h (held), got 0x%03h valid %0b",
                         $time, held_msg, msg_out, msg_valid);
                error_count++;
            end
            if (msg_valid && msg_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: message 0x%03h arrived when none was expected",
                             $time, msg_out);
                    error_count++;
                end else begin
                    exp_msg = exp_q.pop_front();
                    if (msg_out != exp_msg) begin
                        $display("MISMATCH %0t msg_out expected op %0d iter %0d, got op %0d iter %0d",
                                 $time, exp_msg.opcode, exp_msg.iteration,
                                 msg_out.opcode, msg_out.iteration);
                        error_count++;
                    end
                end
            end
            held     = msg_valid && !msg_ready;
            held_msg = msg_out;
            if (row_end) begin
                if (iteration_counter != exp_iter) begin
                    $display("MISMATCH %0t iteration_counter expected %0d, got %0d",
                             $time, exp_iter, iteration_counter);
                    error_count++;
                end
                // zero means the count is not checked for this row
                if (exp_cycles != 0 && cycle_counter != exp_cycles) begin
                    $display("MISMATCH %0t cycle_counter expected %0d, got %0d",
                             $time, exp_cycles, cycle_counter);
                    error_count++;
                end
                if (result_valid != !abort_q) begin
                    $display("MISMATCH %0t result_valid expected %0b, got %0b",
                             $time, !abort_q, result_valid);
                    error_count++;
                end
                if (deadlock != abort_q) begin
                    $display("MISMATCH %0t deadlock expected %0b, got %0b",
                             $time, abort_q, deadlock);
                    error_count++;
                end
                if (exp_q.size() != 0) begin
                    $display("%0t: %0d expected messages never arrived", $time, exp_q.size());
                    error_count++;
                end
                $display("row %0d k=%0d iterations %0d cycles %0d: %s", rows_checked,
                         row_k, iteration_counter, cycle_counter,
                         (error_count == errors_at_start) ? "ok" : "FAILED");
                rows_checked++;
                in_row = 1'b0;
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- tb_decoder_controller.sv
`timescale 1ns/10ps

module tb_decoder_controller import decoder_ctrl_pkg::*; ();

    localparam int spread_delay       = 2;
    localparam int sync_delay         = 2;
    localparam int grow_delay         = 3;
    localparam int deadlock_threshold = 40;
    localparam int fifo_depth         = 16;
    // long enough for the command fifo to fill at k=8
    localparam int hold_cycles        = 70;
    localparam int num_rows           = 9;

    // flying modes
    localparam logic [1:0] fly_none     = 2'd0;
    localparam logic [1:0] fly_burst    = 2'd1;
    localparam logic [1:0] fly_stuck    = 2'd2;
    // ready modes
    localparam logic [1:0] ready_always = 2'd0;
    localparam logic [1:0] ready_random = 2'd1;
    localparam logic [1:0] ready_held   = 2'd2;

    typedef struct packed {
        logic [7:0]                 k;
        logic [1:0]                 flying;
        logic [1:0]                 ready;
        logic [iteration_width-1:0] exp_iter;
        // zero when the cycle count is not checked
        logic [31:0]                exp_cycles;
    } row_t;

    // cycles 2 + (k+1)*6 + k*4 with the delays above
    row_t rows [num_rows] = '{
        '{8'd0, fly_none,  ready_always, 8'd1, 32'd8},
        '{8'd1, fly_none,  ready_always, 8'd2, 32'd18},
        '{8'd3, fly_none,  ready_always, 8'd4, 32'd38},
        '{8'd2, fly_burst, ready_always, 8'd3, 32'd0},
        '{8'd0, fly_stuck, ready_always, 8'd0, 32'd0},
        '{8'd1, fly_none,  ready_always, 8'd2, 32'd18},
        '{8'd4, fly_none,  ready_random, 8'd5, 32'd0},
        '{8'd8, fly_none,  ready_held,   8'd9, 32'd0},
        '{8'd2, fly_burst, ready_random, 8'd3, 32'd0}
    };

    logic                       clk;
    logic                       reset;
    logic                       new_round_start;
    logic                       messages_flying;
    logic                       odd_clusters;
    logic                       msg_ready;
    ctrl_msg_t                  msg_out;
    logic                       msg_valid;
    logic                       result_valid;
    logic [iteration_width-1:0] iteration_counter;
    logic [31:0]                cycle_counter;
    logic                       deadlock;
    logic                       row_start;
    logic                       row_end;
    row_t                       cur;
    int                         row_cycle;
    logic [31:0]                lcg_state = 32'hf484_07fd;
    int                         full_cycles = 0;
    int                         pending;
    int                         check_errors;
    int                         rows_checked;
    int                         tb_errors = 0;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // round length with no stalls, from the stage dwell rules
    function automatic int nominal_cycles(int k);
        return 2 + (k + 1) * (spread_delay + sync_delay + 2) + k * (grow_delay + 1);
    endfunction

    function automatic int run_limit();
        int total;
        total = 200;
        for (int r = 0; r < num_rows; r++) begin
            total += nominal_cycles(int'(rows[r].k));
            if (rows[r].flying == fly_stuck) begin
                total += deadlock_threshold + 2;
            end
            if (rows[r].ready == ready_held) begin
                total += hold_cycles;
            end
            // bursts and random ready can hold each message a little
            if (rows[r].flying == fly_burst || rows[r].ready == ready_random) begin
                total += 2 * (3 * int'(rows[r].k) + 3);
            end
        end
        return total;
    endfunction

    // next falling edge, row dependent inputs
    task automatic next_cycle();
        @(negedge clk);
        row_cycle++;
        lcg_state = lcg_next(lcg_state);
        case (cur.ready)
            ready_random: msg_ready = lcg_state[16];
            ready_held:   msg_ready = (row_cycle > hold_cycles);
            default:      msg_ready = 1'b1;
        endcase
        messages_flying = (cur.flying == fly_stuck) ||
                          (cur.flying == fly_burst && (row_cycle % 7 == 3 || row_cycle % 7 == 4));
        odd_clusters = (iteration_counter < cur.k);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    decoder_controller #(
        .spread_delay       (spread_delay),
        .sync_delay         (sync_delay),
        .grow_delay         (grow_delay),
        .deadlock_threshold (deadlock_threshold),
        .fifo_depth         (fifo_depth)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .new_round_start   (new_round_start),
        .messages_flying   (messages_flying),
        .odd_clusters      (odd_clusters),
        .msg_ready         (msg_ready),
        .msg_out           (msg_out),
        .msg_valid         (msg_valid),
        .result_valid      (result_valid),
        .iteration_counter (iteration_counter),
        .cycle_counter     (cycle_counter),
        .deadlock          (deadlock)
    );

    ctrl_checker checker0 (
        .clk               (clk),
        .reset             (reset),
        .msg_out           (msg_out),
        .msg_valid         (msg_valid),
        .msg_ready         (msg_ready),
        .result_valid      (result_valid),
        .iteration_counter (iteration_counter),
        .cycle_counter     (cycle_counter),
        .deadlock          (deadlock),
        .row_start         (row_start),
        .row_end           (row_end),
        .row_k             (cur.k),
        .row_abort         (cur.flying == fly_stuck),
        .exp_iter          (cur.exp_iter),
        .exp_cycles        (cur.exp_cycles),
        .pending           (pending),
        .error_count       (check_errors),
        .rows_checked      (rows_checked)
    );

    // cycles spent with the command fifo full
    always @(posedge clk) begin
        if (dut0.fifo_full) begin
            full_cycles <= full_cycles + 1;
        end
    end

    initial begin
        int limit;
        int cycles;
        limit  = run_limit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int full_before;
        reset           = 1'b1;
        new_round_start = 1'b0;
        messages_flying = 1'b0;
        odd_clusters    = 1'b0;
        msg_ready       = 1'b0;
        row_start       = 1'b0;
        row_end         = 1'b0;
        cur             = rows[0];
        row_cycle       = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            cur         = rows[r];
            row_cycle   = 0;
            full_before = full_cycles;
            next_cycle();
            new_round_start = 1'b1;
            row_start       = 1'b1;
            next_cycle();
            new_round_start = 1'b0;
            row_start       = 1'b0;
            // round ends in a result or an abort
            while (!result_valid && !deadlock) begin
                next_cycle();
            end
            // let every announced command leave the fifo
            while (pending != 0 || msg_valid) begin
                next_cycle();
            end
            if (cur.ready == ready_held && full_cycles == full_before) begin
                $display("row %0d: command FIFO never filled while ready was held low", r);
                tb_errors++;
            end
            row_end = 1'b1;
            next_cycle();
            row_end = 1'b0;
        end
        $display("rows %0d, checker errors %0d, testbench errors %0d",
                 rows_checked, check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
decoder_ctrl_pkg.sv
command_fifo.sv
stage_sequencer.sv
stall_watchdog.sv
round_statistics.sv
decoder_controller.sv
ctrl_checker.sv
tb_decoder_controller.sv

//--- Makefile
TOP = tb_decoder_controller

sim:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
